//--- rtl/s1c88_arch_pkg.sv
`default_nettype none

package s1c88_arch_pkg;

    // opcode values follow the S1C88 opcode map for the kept instructions
    typedef enum logic [7:0] {
        OP_ADD_A_B     = 8'h01,
        OP_SUB_A_B     = 8'h11,
        OP_AND_A_B     = 8'h21,
        OP_OR_A_B      = 8'h29,
        OP_XOR_A_B     = 8'h39,
        OP_LD_A_MHL    = 8'h45,
        OP_LD_MHL_A    = 8'h78,
        OP_INC_A       = 8'h80,
        OP_LD_A_IMM    = 8'hB0,
        OP_LD_B_IMM    = 8'hB1,
        OP_LD_HL_IMM16 = 8'hC5,
        OP_JRS_C       = 8'hE4,
        OP_JRS_NC      = 8'hE5,
        OP_JRS_Z       = 8'hE6,
        OP_JRS_NZ      = 8'hE7,
        OP_JRS         = 8'hF1,
        OP_NOP         = 8'hFF
    } opcode_t;

    // register selector shared by move sources, move destinations and bus transfers
    typedef enum logic [3:0] {
        R_NONE  = 4'h0,
        R_A     = 4'h1,
        R_B     = 4'h2,
        R_BA    = 4'h3,
        R_H     = 4'h4,
        R_L     = 4'h5,
        R_HL    = 4'h6,
        R_PC    = 4'h7,
        R_DATA  = 4'h8,
        R_IMML  = 4'h9,
        R_IMMH  = 4'hA,
        R_IMM   = 4'hB,
        R_ALU_A = 4'hC,
        R_ALU_B = 4'hD,
        R_ALU_R = 4'hE
    } reg_id_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_INC = 3'd5
    } alu_op_t;

    // flag positions inside SC
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 3;

    localparam logic [7:0] SC_RESET = 8'hC0;

    typedef enum logic [1:0] {
        BS_IDLE      = 2'd0,
        BS_IRQ_READ  = 2'd1,
        BS_MEM_WRITE = 2'd2,
        BS_MEM_READ  = 2'd3
    } bus_status_t;

endpackage

`default_nettype wire

//--- rtl/s1c88_micro_pkg.sv
`default_nettype none

package s1c88_micro_pkg;

    import s1c88_arch_pkg::*;

    typedef enum logic [1:0] {
        MT_MISC = 2'd0,
        MT_BUS  = 2'd1,
        MT_JMP  = 2'd2
    } micro_type_t;

    typedef enum logic [1:0] {
        AM_HL  = 2'd0,
        AM_IMM = 2'd1
    } addr_mode_t;

    typedef enum logic [2:0] {
        COND_ALWAYS = 3'd0,
        COND_C      = 3'd1,
        COND_NC     = 3'd2,
        COND_Z      = 3'd3,
        COND_NZ     = 3'd4
    } cond_t;

    // fields common to every view of the micro word sit in bits 31 down to 25
    typedef struct packed {
        micro_type_t mtype;
        logic        done;
        alu_op_t     alu_op;
        logic        flag_we;
    } micro_head_t;

    typedef struct packed {
        micro_head_t head;
        reg_id_t     dst;
        reg_id_t     src;
        logic [16:0] spare;
    } micro_misc_t;

    typedef struct packed {
        micro_head_t head;
        reg_id_t     rid;
        addr_mode_t  mode;
        logic        wr;
        logic [17:0] spare;
    } micro_bus_t;

    typedef struct packed {
        micro_head_t head;
        cond_t       cond;
        logic [21:0] spare;
    } micro_jmp_t;

    // the type field in the head selects which view applies
    typedef union packed {
        micro_misc_t misc;
        micro_bus_t  bus;
        micro_jmp_t  jmp;
    } micro_word_t;

endpackage

`default_nettype wire

//--- rtl/s1c88_microcode_rom.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88_microcode_rom
    import s1c88_arch_pkg::*;
    import s1c88_micro_pkg::*;
#(
    parameter int MICRO_AW = 6
)
(
    input  opcode_t             opcode,
    input  logic [MICRO_AW-1:0] micro_addr,
    output logic [MICRO_AW-1:0] entry,
    output micro_word_t         word
);
    // first microaddress of each micro-program
    localparam int E_NOP      = 0;
    localparam int E_LD_A     = 1;
    localparam int E_LD_B     = 3;
    localparam int E_LD_HL    = 5;
    localparam int E_LD_A_MHL = 8;
    localparam int E_LD_MHL_A = 10;
    localparam int E_ADD      = 12;
    localparam int E_SUB      = 15;
    localparam int E_AND      = 18;
    localparam int E_OR       = 21;
    localparam int E_XOR      = 24;
    localparam int E_INC      = 27;
    localparam int E_JRS      = 29;
    localparam int E_JRS_C    = 32;
    localparam int E_JRS_NC   = 35;
    localparam int E_JRS_Z    = 38;
    localparam int E_JRS_NZ   = 41;

    function automatic micro_word_t misc_w(input reg_id_t dst, input reg_id_t src,
                                           input alu_op_t op, input logic flag_we,
                                           input logic done);
        micro_word_t w;
        w = '0;
        w.misc.head.mtype   = MT_MISC;
        w.misc.head.done    = done;
        w.misc.head.alu_op  = op;
        w.misc.head.flag_we = flag_we;
        w.misc.dst          = dst;
        w.misc.src          = src;
        return w;
    endfunction

    function automatic micro_word_t mov_w(input reg_id_t dst, input reg_id_t src);
        return misc_w(dst, src, ALU_ADD, 1'b0, 1'b0);
    endfunction

    function automatic micro_word_t bus_w(input reg_id_t rid, input addr_mode_t mode,
                                          input logic wr);
        micro_word_t w;
        w = '0;
        w.bus.head.mtype = MT_BUS;
        w.bus.rid        = rid;
        w.bus.mode       = mode;
        w.bus.wr         = wr;
        return w;
    endfunction

    function automatic micro_word_t jmp_w(input cond_t cond);
        micro_word_t w;
        w = '0;
        w.jmp.head.mtype = MT_JMP;
        w.jmp.cond       = cond;
        return w;
    endfunction

    always_comb
    begin
        case (opcode)
            OP_LD_A_IMM:    entry = MICRO_AW'(E_LD_A);
            OP_LD_B_IMM:    entry = MICRO_AW'(E_LD_B);
            OP_LD_HL_IMM16: entry = MICRO_AW'(E_LD_HL);
            OP_LD_A_MHL:    entry = MICRO_AW'(E_LD_A_MHL);
            OP_LD_MHL_A:    entry = MICRO_AW'(E_LD_MHL_A);
            OP_ADD_A_B:     entry = MICRO_AW'(E_ADD);
            OP_SUB_A_B:     entry = MICRO_AW'(E_SUB);
            OP_AND_A_B:     entry = MICRO_AW'(E_AND);
            OP_OR_A_B:      entry = MICRO_AW'(E_OR);
            OP_XOR_A_B:     entry = MICRO_AW'(E_XOR);
            OP_INC_A:       entry = MICRO_AW'(E_INC);
            OP_JRS:         entry = MICRO_AW'(E_JRS);
            OP_JRS_C:       entry = MICRO_AW'(E_JRS_C);
            OP_JRS_NC:      entry = MICRO_AW'(E_JRS_NC);
            OP_JRS_Z:       entry = MICRO_AW'(E_JRS_Z);
            OP_JRS_NZ:      entry = MICRO_AW'(E_JRS_NZ);
            default:        entry = MICRO_AW'(E_NOP);
        endcase
    end

    // a jump word has no done bit because a taken jump ends the instruction by itself
    always_comb
    begin
        case (int'(micro_addr))
            1:  word = mov_w(R_A, R_DATA);
            3:  word = mov_w(R_B, R_DATA);
            5:  word = mov_w(R_L, R_DATA);
            6:  word = mov_w(R_H, R_DATA);
            8:  word = bus_w(R_A, AM_HL, 1'b0);
            10: word = bus_w(R_A, AM_HL, 1'b1);
            12, 15, 18, 21, 24, 27:
                word = mov_w(R_ALU_A, R_A);
            13, 16, 19, 22, 25:
                word = mov_w(R_ALU_B, R_B);
            14: word = misc_w(R_A, R_ALU_R, ALU_ADD, 1'b1, 1'b1);
            17: word = misc_w(R_A, R_ALU_R, ALU_SUB, 1'b1, 1'b1);
            20: word = misc_w(R_A, R_ALU_R, ALU_AND, 1'b1, 1'b1);
            23: word = misc_w(R_A, R_ALU_R, ALU_OR, 1'b1, 1'b1);
            26: word = misc_w(R_A, R_ALU_R, ALU_XOR, 1'b1, 1'b1);
            28: word = misc_w(R_A, R_ALU_R, ALU_INC, 1'b1, 1'b1);
            29, 32, 35, 38, 41:
                word = mov_w(R_IMML, R_DATA);
            30: word = jmp_w(COND_ALWAYS);
            33: word = jmp_w(COND_C);
            36: word = jmp_w(COND_NC);
            39: word = jmp_w(COND_Z);
            42: word = jmp_w(COND_NZ);
            // the NOP entry and every closing step of a micro-program
            default:
                word = misc_w(R_NONE, R_NONE, ALU_ADD, 1'b0, 1'b1);
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/s1c88_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88_sequencer
    import s1c88_arch_pkg::*;
    import s1c88_micro_pkg::*;
#(
    parameter int MICRO_AW = 6
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  data_in,
    input  logic        jump_taken,
    output logic        phase,
    output logic        fetch,
    output logic        last_step,
    output micro_word_t micro_op
);
    logic [1:0]          hold_cnt;
    logic                running;
    opcode_t             opcode;
    logic [MICRO_AW-1:0] entry;
    logic [MICRO_AW-1:0] micro_pc;
    logic [MICRO_AW-1:0] micro_addr;

    // the machine cycle starts a couple of clocks after reset is released
    assign running = (hold_cnt == 2'd2);

    assign micro_addr = entry + micro_pc;
    assign last_step  = micro_op.misc.head.done;

    // the last step overlaps the next fetch, and so does a taken jump
    assign fetch = running && (last_step || jump_taken);

    s1c88_microcode_rom #(
        .MICRO_AW(MICRO_AW)
    ) microcode_rom (
        .opcode(opcode),
        .micro_addr(micro_addr),
        .entry(entry),
        .word(micro_op)
    );

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            hold_cnt <= 2'd0;
            phase    <= 1'b0;
            opcode   <= OP_NOP;
            micro_pc <= '0;
        end
        else if (!running)
        begin
            hold_cnt <= hold_cnt + 2'd1;
        end
        else
        begin
            phase <= !phase;
            // everything moves on at the end of the data clock
            if (phase)
            begin
                if (fetch)
                begin
                    opcode   <= opcode_t'(data_in);
                    micro_pc <= '0;
                end
                else
                begin
                    micro_pc <= micro_pc + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/s1c88_alu.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88_alu
    import s1c88_arch_pkg::*;
(
    input  alu_op_t    op,
    input  logic [7:0] a,
    input  logic [7:0] b,
    output logic [7:0] result,
    output logic [3:0] flags
);
    // bit 8 holds the carry, or the borrow for a subtraction
    logic [8:0] sum;
    logic       overflow;

    always_comb
    begin
        overflow = 1'b0;
        case (op)
            ALU_ADD:
            begin
                sum      = {1'b0, a} + {1'b0, b};
                overflow = (a[7] == b[7]) && (sum[7] != a[7]);
            end
            ALU_SUB:
            begin
                sum      = {1'b0, a} - {1'b0, b};
                overflow = (a[7] != b[7]) && (sum[7] != a[7]);
            end
            ALU_AND: sum = {1'b0, a & b};
            ALU_OR:  sum = {1'b0, a | b};
            ALU_XOR: sum = {1'b0, a ^ b};
            ALU_INC:
            begin
                sum      = {1'b0, a} + 9'd1;
                overflow = (a == 8'h7F);
            end
            default: sum = {1'b0, a};
        endcase
    end

    assign result = sum[7:0];

    always_comb
    begin
        flags         = 4'd0;
        flags[FLAG_Z] = (sum[7:0] == 8'h00);
        flags[FLAG_C] = sum[8];
        flags[FLAG_V] = overflow;
        flags[FLAG_N] = sum[7];
    end

endmodule

`default_nettype wire

//--- rtl/s1c88_execute.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88_execute
    import s1c88_arch_pkg::*;
    import s1c88_micro_pkg::*;
#(
    parameter logic [15:0] RESET_PC = 16'h0000
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic        phase,
    input  logic        fetch,
    input  micro_word_t micro_op,
    input  logic [7:0]  data_in,
    output logic [15:0] pc,
    output logic [15:0] hl,
    output logic [15:0] imm,
    output logic [7:0]  wdata,
    output logic        jump_taken
);
    micro_head_t head;
    logic [15:0] ba;
    logic [7:0]  sc;
    logic [15:0] pc_q;
    logic [15:0] top_addr;
    logic [7:0]  imm_lo;
    logic [7:0]  imm_hi;
    logic [7:0]  alu_a;
    logic [7:0]  alu_b;
    logic [7:0]  alu_r;
    logic [3:0]  alu_flags;
    logic [15:0] src_val;
    logic [15:0] bus_val;
    logic [15:0] jump_dest;
    logic        imm_read;
    logic        cond_true;

    assign head = micro_op.misc.head;
    assign imm  = {imm_hi, imm_lo};

    function automatic logic [15:0] read_reg(input reg_id_t id);
        case (id)
            R_A:     return {8'h00, ba[7:0]};
            R_B:     return {8'h00, ba[15:8]};
            R_BA:    return ba;
            R_H:     return {8'h00, hl[15:8]};
            R_L:     return {8'h00, hl[7:0]};
            R_HL:    return hl;
            R_PC:    return pc_q;
            R_DATA:  return {8'h00, data_in};
            R_IMML:  return {8'h00, imm_lo};
            R_IMMH:  return {8'h00, imm_hi};
            R_IMM:   return {imm_hi, imm_lo};
            R_ALU_A: return {8'h00, alu_a};
            R_ALU_B: return {8'h00, alu_b};
            R_ALU_R: return {8'h00, alu_r};
            default: return 16'h0000;
        endcase
    endfunction

    task write_reg(input reg_id_t id, input logic [15:0] value);
        case (id)
            R_A:     ba[7:0]  <= value[7:0];
            R_B:     ba[15:8] <= value[7:0];
            R_BA:    ba       <= value;
            R_H:     hl[15:8] <= value[7:0];
            R_L:     hl[7:0]  <= value[7:0];
            R_HL:    hl       <= value;
            R_IMML:  imm_lo   <= value[7:0];
            R_IMMH:  imm_hi   <= value[7:0];
            R_IMM:   {imm_hi, imm_lo} <= value;
            R_ALU_A: alu_a    <= value[7:0];
            R_ALU_B: alu_b    <= value[7:0];
            default:
            begin
            end
        endcase
    endtask

    always_comb
    begin
        src_val = read_reg(micro_op.misc.src);
        bus_val = read_reg(micro_op.bus.rid);
    end

    assign wdata = bus_val[7:0];

    s1c88_alu alu (
        .op(head.alu_op),
        .a(alu_a),
        .b(alu_b),
        .result(alu_r),
        .flags(alu_flags)
    );

    always_comb
    begin
        case (micro_op.jmp.cond)
            COND_C:  cond_true = sc[FLAG_C];
            COND_NC: cond_true = !sc[FLAG_C];
            COND_Z:  cond_true = sc[FLAG_Z];
            COND_NZ: cond_true = !sc[FLAG_Z];
            default: cond_true = 1'b1;
        endcase
    end

    // the offset is relative to the opcode address plus the two instruction bytes
    assign jump_dest  = top_addr + 16'd2 + {{8{imm_lo[7]}}, imm_lo};
    assign jump_taken = (head.mtype == MT_JMP) && cond_true;
    assign pc         = jump_taken ? jump_dest : pc_q;

    // an immediate byte is read from the code stream at PC
    assign imm_read = (head.mtype == MT_MISC) && (micro_op.misc.src == R_DATA);

    always_ff @(posedge clk)
    begin
        if (phase)
        begin
            if (head.mtype == MT_MISC)
                write_reg(micro_op.misc.dst, src_val);
            else if (head.mtype == MT_BUS && !micro_op.bus.wr)
                write_reg(micro_op.bus.rid, {8'h00, data_in});
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            sc       <= SC_RESET;
            pc_q     <= RESET_PC;
            top_addr <= RESET_PC;
        end
        else if (phase)
        begin
            if (head.flag_we)
            begin
                case (head.alu_op)
                    ALU_AND, ALU_OR, ALU_XOR:
                    begin
                        sc[FLAG_Z] <= alu_flags[FLAG_Z];
                        sc[FLAG_N] <= alu_flags[FLAG_N];
                    end
                    ALU_ADD, ALU_SUB:
                    begin
                        sc[FLAG_Z] <= alu_flags[FLAG_Z];
                        sc[FLAG_C] <= alu_flags[FLAG_C];
                        sc[FLAG_V] <= alu_flags[FLAG_V];
                        sc[FLAG_N] <= alu_flags[FLAG_N];
                    end
                    ALU_INC: sc[FLAG_Z] <= alu_flags[FLAG_Z];
                    default:
                    begin
                    end
                endcase
            end

            // a fetch at a jump destination restarts the count from there
            if (fetch)
            begin
                top_addr <= pc;
                pc_q     <= pc + 16'd1;
            end
            else if (imm_read)
            begin
                pc_q <= pc_q + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/s1c88_bus_unit.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88_bus_unit
    import s1c88_arch_pkg::*;
    import s1c88_micro_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        phase,
    input  logic        fetch,
    input  micro_word_t micro_op,
    input  logic [15:0] pc,
    input  logic [15:0] hl,
    input  logic [15:0] imm,
    input  logic [7:0]  wdata,
    output logic [23:0] address_out,
    output logic [7:0]  data_out,
    output bus_status_t bus_status,
    output logic        read,
    output logic        write,
    output logic        sync
);
    logic        code_read;
    logic        data_cycle;
    logic [15:0] data_addr;

    assign code_read  = fetch ||
        (micro_op.misc.head.mtype == MT_MISC && micro_op.misc.src == R_DATA);
    assign data_cycle = (micro_op.bus.head.mtype == MT_BUS);
    assign data_addr  = (micro_op.bus.mode == AM_IMM) ? imm : hl;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            address_out <= '1;
            data_out    <= '1;
            bus_status  <= BS_IDLE;
            read        <= 1'b0;
            write       <= 1'b0;
            sync        <= 1'b0;
        end
        else if (!phase)
        begin
            // the address holds over idle cycles
            sync       <= fetch;
            read       <= 1'b0;
            write      <= 1'b0;
            bus_status <= BS_IDLE;
            if (code_read)
            begin
                address_out <= {9'd0, pc[14:0]};
                bus_status  <= BS_MEM_READ;
                read        <= 1'b1;
            end
            else if (data_cycle)
            begin
                address_out <= {8'd0, data_addr};
                if (micro_op.bus.wr)
                begin
                    bus_status <= BS_MEM_WRITE;
                    write      <= 1'b1;
                    data_out   <= wdata;
                end
                else
                begin
                    bus_status <= BS_MEM_READ;
                    read       <= 1'b1;
                end
            end
        end
        else
        begin
            // strobes drop on the edge where the memory data is taken
            read  <= 1'b0;
            write <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/s1c88.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88
    import s1c88_arch_pkg::*;
    import s1c88_micro_pkg::*;
#(
    parameter logic [15:0] RESET_PC = 16'h0100,
    parameter int          MICRO_AW = 6
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  data_in,
    output logic [7:0]  data_out,
    output logic [23:0] address_out,
    output bus_status_t bus_status,
    output logic        read,
    output logic        write,
    output logic        sync
);
    logic        phase;
    logic        fetch;
    logic        last_step;
    logic        jump_taken;
    micro_word_t micro_op;
    logic [15:0] pc;
    logic [15:0] hl;
    logic [15:0] imm;
    logic [7:0]  wdata;

    s1c88_sequencer #(
        .MICRO_AW(MICRO_AW)
    ) sequencer (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .jump_taken(jump_taken),
        .phase(phase),
        .fetch(fetch),
        .last_step(last_step),
        .micro_op(micro_op)
    );

    s1c88_execute #(
        .RESET_PC(RESET_PC)
    ) execute (
        .clk(clk),
        .reset(reset),
        .phase(phase),
        .fetch(fetch),
        .micro_op(micro_op),
        .data_in(data_in),
        .pc(pc),
        .hl(hl),
        .imm(imm),
        .wdata(wdata),
        .jump_taken(jump_taken)
    );

    s1c88_bus_unit bus_unit (
        .clk(clk),
        .reset(reset),
        .phase(phase),
        .fetch(fetch),
        .micro_op(micro_op),
        .pc(pc),
        .hl(hl),
        .imm(imm),
        .wdata(wdata),
        .address_out(address_out),
        .data_out(data_out),
        .bus_status(bus_status),
        .read(read),
        .write(write),
        .sync(sync)
    );

endmodule

`default_nettype wire

//--- verif/s1c88_tb.sv
`timescale 1ns/1ps
`default_nettype none

module s1c88_tb
    import s1c88_arch_pkg::*;
();
    localparam logic [15:0] START_PC     = 16'h0100;
    localparam int          SEED         = 77968;
    localparam int          RESET_CYCLES = 8;
    localparam int          FIRST_FETCH  = 4;
    localparam int          RUN_LIMIT    = 20000;

    logic        clk;
    logic        reset;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic [23:0] address_out;
    bus_status_t bus_status;
    logic        read;
    logic        write;
    logic        sync;

    // code lives below 8000 hex in the 64 KB memory and data above it
    logic [7:0]  mem [0:65535];
    // the fetch address that has to follow each JRS opcode address
    logic        jump_check [0:65535];
    logic [15:0] jump_dest [0:65535];
    logic [15:0] write_addr_q [$];
    logic [7:0]  write_data_q [$];
    logic [15:0] code_ptr;
    logic        dest_pending;
    logic [15:0] dest_expected;
    int          error_count;

    s1c88 #(
        .RESET_PC(START_PC),
        .MICRO_AW(6)
    ) UUT (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .data_out(data_out),
        .address_out(address_out),
        .bus_status(bus_status),
        .read(read),
        .write(write),
        .sync(sync)
    );

    always #20 clk = !clk;

    task automatic stop_run();
        error_count = error_count + 1;
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] time %0t: %s expected 0x%0h, actual 0x%0h",
                 $time, name, expected, actual);
        stop_run();
    endtask

    task automatic report_failure(input string what);
        $display("%s (time %0t)", what, $time);
        stop_run();
    endtask

    task automatic check_reset_outputs();
        assert (read == 1'b0) else report_mismatch("read", 0, read);
        assert (write == 1'b0) else report_mismatch("write", 0, write);
        assert (sync == 1'b0) else report_mismatch("sync", 0, sync);
        assert (bus_status == BS_IDLE) else report_mismatch("bus_status", BS_IDLE, bus_status);
        assert (address_out == 24'hFFFFFF)
        else
            report_mismatch("address_out", 24'hFFFFFF, address_out);
        assert (data_out == 8'hFF) else report_mismatch("data_out", 8'hFF, data_out);
    endtask

    // returns {zero, carry, result} as the instruction set defines them
    function automatic logic [9:0] model_alu(input opcode_t op, input logic [7:0] a,
                                             input logic [7:0] b);
        logic [8:0] wide;
        logic [7:0] r;
        logic       c;
        c = 1'b0;
        case (op)
            OP_ADD_A_B:
            begin
                wide = {1'b0, a} + {1'b0, b};
                r    = wide[7:0];
                c    = wide[8];
            end
            OP_SUB_A_B:
            begin
                r = a - b;
                c = (a < b);
            end
            OP_AND_A_B: r = a & b;
            OP_OR_A_B:  r = a | b;
            OP_XOR_A_B: r = a ^ b;
            default:    r = a + 8'd1;
        endcase
        return {(r == 8'h00), c, r};
    endfunction

    task automatic emit(input logic [7:0] value);
        mem[code_ptr] = value;
        code_ptr      = code_ptr + 16'd1;
    endtask

    task automatic emit_ld_a(input logic [7:0] value);
        emit(OP_LD_A_IMM);
        emit(value);
    endtask

    task automatic emit_ld_b(input logic [7:0] value);
        emit(OP_LD_B_IMM);
        emit(value);
    endtask

    // the low byte of the 16-bit immediate comes first
    task automatic emit_ld_hl(input logic [15:0] value);
        emit(OP_LD_HL_IMM16);
        emit(value[7:0]);
        emit(value[15:8]);
    endtask

    task automatic build_alu_round();
        opcode_t     ops [0:5];
        logic [31:0] rnd;
        logic [15:0] addr;
        logic [7:0]  a;
        logic [9:0]  res;
        ops[0] = OP_ADD_A_B;
        ops[1] = OP_SUB_A_B;
        ops[2] = OP_AND_A_B;
        ops[3] = OP_OR_A_B;
        ops[4] = OP_XOR_A_B;
        ops[5] = OP_INC_A;
        rnd  = $urandom();
        addr = {2'b10, rnd[13:0]};
        a    = rnd[21:14];
        emit_ld_hl(addr);
        emit_ld_a(a);
        rnd = $urandom();
        emit_ld_b(rnd[7:0]);
        // A carries over from one operation to the next
        for (int i = 0; i < 6; i++)
        begin
            emit(ops[i]);
            emit(OP_LD_MHL_A);
            res = model_alu(ops[i], a, rnd[7:0]);
            a   = res[7:0];
            write_addr_q.push_back(addr);
            write_data_q.push_back(a);
        end
    endtask

    task automatic build_inc_round(input int round);
        logic [31:0] rnd;
        logic [15:0] addr;
        logic [7:0]  value;
        rnd   = $urandom();
        addr  = {2'b11, round[5:0], rnd[7:0]};
        value = rnd[15:8];
        mem[addr] = value;
        emit_ld_hl(addr);
        emit(OP_LD_A_MHL);
        emit(OP_INC_A);
        emit(OP_LD_MHL_A);
        write_addr_q.push_back(addr);
        write_data_q.push_back(value + 8'd1);
    endtask

    task automatic build_branch_round(input opcode_t jrs_op, input opcode_t alu_op);
        logic [31:0] rnd;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  offset;
        logic [9:0]  res;
        logic [15:0] jrs_addr;
        logic        taken;
        rnd    = $urandom();
        a      = rnd[7:0];
        b      = rnd[15:8];
        offset = {5'd0, rnd[26:24]} + 8'd1;
        // now and then pick operands that give a zero result
        if (rnd[17:16] == 2'd0)
        begin
            if (alu_op == OP_SUB_A_B)
                b = a;
            else
                b = 8'd0 - a;
        end
        res = model_alu(alu_op, a, b);
        case (jrs_op)
            OP_JRS_C:  taken = res[8];
            OP_JRS_NC: taken = !res[8];
            OP_JRS_Z:  taken = res[9];
            OP_JRS_NZ: taken = !res[9];
            default:   taken = 1'b1;
        endcase
        emit_ld_a(a);
        emit_ld_b(b);
        emit(alu_op);
        jrs_addr = code_ptr;
        emit(jrs_op);
        emit(offset);
        jump_check[jrs_addr] = 1'b1;
        if (taken)
            jump_dest[jrs_addr] = jrs_addr + 16'd2 + {8'd0, offset};
        else
            jump_dest[jrs_addr] = jrs_addr + 16'd2;
        // the fall-through path slides over NOPs to the jump target
        for (int i = 0; i < offset; i++)
            emit(OP_NOP);
    endtask

    // the memory model answers reads and stores writes
    always @(negedge clk)
    begin
        if (read)
            data_in = mem[address_out[15:0]];
        if (write)
            mem[address_out[15:0]] = data_out;
    end

    always @(negedge clk)
    begin
        if (reset)
        begin
            check_reset_outputs();
        end
        else
        begin
            assert (!(read && write)) else report_failure("read and write are high together");
            if (sync && read)
            begin
                assert (address_out[23:15] == 9'd0)
                else
                    report_mismatch("address_out[23:15]", 0, address_out[23:15]);
            end
            if (read || write)
            begin
                assert (address_out[23:16] == 8'd0)
                else
                    report_mismatch("address_out[23:16]", 0, address_out[23:16]);
            end
            if (read)
            begin
                assert (bus_status == BS_MEM_READ)
                else
                    report_mismatch("bus_status", BS_MEM_READ, bus_status);
            end
        end
    end

    always @(negedge clk)
    begin
        logic [15:0] exp_addr;
        logic [7:0]  exp_data;
        if (!reset && write)
        begin
            if (write_addr_q.size() == 0)
            begin
                report_failure("memory write that the program does not make");
            end
            else
            begin
                exp_addr = write_addr_q.pop_front();
                exp_data = write_data_q.pop_front();
                assert (address_out == {8'h00, exp_addr})
                else
                    report_mismatch("address_out", {8'h00, exp_addr}, address_out);
                assert (data_out == exp_data) else report_mismatch("data_out", exp_data, data_out);
                assert (bus_status == BS_MEM_WRITE)
                else
                    report_mismatch("bus_status", BS_MEM_WRITE, bus_status);
            end
        end
    end

    // each opcode fetch after a JRS has to land where the flags send it
    always @(negedge clk)
    begin
        if (!reset && sync && read)
        begin
            if (dest_pending)
            begin
                assert (address_out == {8'h00, dest_expected})
                else
                    report_mismatch("address_out", {8'h00, dest_expected}, address_out);
                dest_pending = 1'b0;
            end
            if (jump_check[address_out[15:0]])
            begin
                dest_pending  = 1'b1;
                dest_expected = jump_dest[address_out[15:0]];
            end
        end
    end

    initial
    begin
        opcode_t     conds [0:3];
        opcode_t     alu_sel;
        logic [31:0] seed_draw;
        logic [15:0] end_addr;
        int          wait_count;
        int          end_fetches;
        logic        done;
        clk          = 1'b0;
        reset        = 1'b1;
        data_in      = 8'h00;
        error_count  = 0;
        dest_pending = 1'b0;
        code_ptr     = START_PC;
        seed_draw    = $urandom(SEED);
        conds[0]     = OP_JRS_C;
        conds[1]     = OP_JRS_NC;
        conds[2]     = OP_JRS_Z;
        conds[3]     = OP_JRS_NZ;

        for (int i = 0; i < 65536; i++)
        begin
            mem[i]        = 8'(i) ^ 8'(i >> 8) ^ 8'h3C;
            jump_check[i] = 1'b0;
            jump_dest[i]  = 16'h0000;
        end

        for (int r = 0; r < 4; r++)
            build_alu_round();
        for (int r = 0; r < 4; r++)
            build_inc_round(r);
        for (int r = 0; r < 4; r++)
        begin
            if (r % 2 == 0)
                alu_sel = OP_ADD_A_B;
            else
                alu_sel = OP_SUB_A_B;
            for (int k = 0; k < 4; k++)
                build_branch_round(conds[k], alu_sel);
        end
        // the program ends in a jump to itself
        end_addr = code_ptr;
        emit(OP_JRS);
        emit(8'hFE);
        jump_check[end_addr] = 1'b1;
        jump_dest[end_addr]  = end_addr;

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        wait_count = 0;
        done       = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            wait_count++;
            if (sync)
                done = 1'b1;
            else if (wait_count >= FIRST_FETCH)
                report_failure("no opcode fetch within 4 clocks after reset");
            else
                check_reset_outputs();
        end
        assert (address_out == {8'h00, START_PC})
        else
            report_mismatch("address_out", {8'h00, START_PC}, address_out);
        assert (read == 1'b1) else report_mismatch("read", 1, read);

        wait_count  = 0;
        end_fetches = 0;
        done        = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            wait_count++;
            if (sync && read && address_out[15:0] == end_addr)
                end_fetches++;
            if (end_fetches >= 2)
                done = 1'b1;
            else if (wait_count >= RUN_LIMIT)
                report_failure("the program never reached its closing loop");
        end
        assert (write_addr_q.size() == 0)
        else
            report_failure("some expected memory writes never happened");

        if (error_count == 0)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
        begin
            $display("=== FAIL ===");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/s1c88_arch_pkg.sv
rtl/s1c88_micro_pkg.sv
rtl/s1c88_microcode_rom.sv
rtl/s1c88_sequencer.sv
rtl/s1c88_alu.sv
rtl/s1c88_execute.sv
rtl/s1c88_bus_unit.sv
rtl/s1c88.sv
verif/s1c88_tb.sv
